//--- ipv4_ttl_path.f
+incdir+hw
hw/axis_types_pkg.sv
hw/ipv4_hdr_pkg.sv
hw/hdr_beat_counter.sv
hw/hdr_edit_fsm.sv
hw/ipv4_checksum_unit.sv
hw/ipv4_hdr_editor.sv
hw/ipv4_ttl_path.sv
sim/tb_ipv4_ttl_path.sv

//--- run_sim.sh
#!/bin/sh
# build the ipv4 ttl path testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_ipv4_ttl_path -Mdir "$BUILD_DIR" \
    -f ipv4_ttl_path.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_ipv4_ttl_path" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the fail message on any error or timeout
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- sim/tb_ipv4_ttl_path.sv
//////////////////////////////////////////////////
// ipv4 ttl path testbench
// directed packets against a header reference model
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module tb_ipv4_ttl_path;

    timeunit 1ns;
    timeprecision 100ps;

    import axis_types_pkg::*;
    import ipv4_hdr_pkg::*;

    // beats over all tests, 4 x 5 + runt 2 + back-to-back 25
    localparam int TOTAL_BEATS     = 47;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 100;

    logic      packet_data_in;
    logic      rst;
    logic      s_valid;
    logic      s_ready;
    in_beat_t  s_beat;
    logic      m_valid;
    logic      m_ready;
    out_beat_t m_beat;

    in_beat_t   tx_q [$];
    out_beat_t  exp_q [$];
    out_beat_t  rx_q [$];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;

    ipv4_ttl_path i_dut (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .s_beat         (s_beat),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_beat         (m_beat)
    );

    initial begin
        packet_data_in = 1'b0;
        forever #10 packet_data_in = ~packet_data_in;
    end

    //////////////////////////////////////////////////
    // helpers

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic take_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], take_bit()};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED time %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic compare_beat(input out_beat_t got, input out_beat_t expected);
        check_value("m_beat.data", 128'(got.data), 128'(expected.data));
        check_value("m_beat.keep", 128'(got.keep), 128'(expected.keep));
        check_value("m_beat.last", 128'(got.last), 128'(expected.last));
        check_value("m_beat.meta.port_id", 128'(got.meta.port_id),
                    128'(expected.meta.port_id));
        check_value("m_beat.meta.hdr_ok", 128'(got.meta.hdr_ok),
                    128'(expected.meta.hdr_ok));
        check_value("m_beat.meta.ttl_expired", 128'(got.meta.ttl_expired),
                    128'(expected.meta.ttl_expired));
    endtask

    //////////////////////////////////////////////////
    // reference model

    // ones-complement sum of the ten header words
    function automatic csum_t word_sum(input logic [159:0] h);
        logic [16:0] s;
        csum_t       acc;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            s   = {1'b0, acc} + {1'b0, h[159-16*i -: 16]};
            acc = s[15:0] + {15'd0, s[16]};
        end
        return acc;
    endfunction

    // checksum field is bytes 10 and 11
    function automatic logic [159:0] seal_header(input logic [159:0] h);
        logic [159:0] r;
        r          = h;
        r[79:64]   = 16'h0000;
        r[79:64]   = ~word_sum(r);
        return r;
    endfunction

    function automatic logic [159:0] make_header(input logic [7:0] ver_ihl, input ttl_t ttl,
                                                 input ipv4_word_t id);
        logic [159:0] h;
        // udp, don't fragment, 192.168.10.1 to 10.0.0.5
        h = {ver_ihl, 8'h00, 16'd60, id, 16'h4000, ttl, 8'h11, 16'h0000,
             32'hc0a8_0a01, 32'h0a00_0005};
        return seal_header(h);
    endfunction

    // ttl minus one, then a full recompute of the checksum
    function automatic logic [159:0] forward_header(input logic [159:0] h);
        logic [159:0] r;
        r          = h;
        r[95:88]   = h[95:88] - 8'd1;
        return seal_header(r);
    endfunction

    // queues the input beats and the beats the DUT should emit
    task automatic add_packet(input logic [159:0] h, input int nbeats, input port_id_t port,
                              input beat_keep_t last_keep);
        logic         ok;
        logic         expired;
        logic [159:0] oh;
        beat_data_t   pay;
        in_beat_t     ib;
        out_beat_t    ob;
        // a runt never gets a verdict
        ok      = (nbeats >= `IPV4_TTL_HDR_BEATS) && (word_sum(h) == 16'hffff) &&
                  (h[159:152] == `IPV4_TTL_VER_IHL);
        expired = ok && (h[95:88] == 8'd0);
        oh      = (ok && !expired) ? forward_header(h) : h;
        for (int k = 0; k < nbeats; k++) begin
            pay             = rand_bits(64);
            ib.keep         = (k == nbeats - 1) ? last_keep : 8'hff;
            ib.last         = (k == nbeats - 1);
            ib.meta.port_id = port;
            case (k)
                0: begin
                    ib.data = h[159:96];
                    ob.data = oh[159:96];
                end
                1: begin
                    ib.data = h[95:32];
                    ob.data = oh[95:32];
                end
                // header tail in the top half, payload below
                2: begin
                    ib.data = {h[31:0], pay[31:0]};
                    ob.data = {oh[31:0], pay[31:0]};
                end
                default: begin
                    ib.data = pay;
                    ob.data = pay;
                end
            endcase
            ob.keep             = ib.keep;
            ob.last             = ib.last;
            ob.meta.port_id     = port;
            ob.meta.hdr_ok      = ok;
            ob.meta.ttl_expired = expired;
            tx_q.push_back(ib);
            exp_q.push_back(ob);
        end
    endtask

    //////////////////////////////////////////////////
    // stream driver and monitor

    task automatic run_stream(input logic random_ready);
        int        sent;
        int        got;
        logic      stalled;
        out_beat_t held;
        sent    = 0;
        got     = 0;
        stalled = 1'b0;
        held    = '0;
        rx_q.delete();
        @(posedge packet_data_in);
        s_valid <= (tx_q.size() > 0);
        s_beat  <= tx_q[0];
        m_ready <= random_ready ? take_bit() : 1'b1;
        while (got < exp_q.size()) begin
            @(posedge packet_data_in);
            // a stalled beat must hold until taken
            if (stalled) begin
                check_value("m_valid while stalled", 128'(m_valid), 128'(1'b1));
                check_value("m_beat while stalled", 128'(m_beat), 128'(held));
            end
            stalled = m_valid && !m_ready;
            held    = m_beat;
            if (s_valid && s_ready) begin
                sent++;
            end
            if (m_valid && m_ready) begin
                compare_beat(m_beat, exp_q[got]);
                rx_q.push_back(m_beat);
                got++;
            end
            if (sent < tx_q.size()) begin
                s_valid <= 1'b1;
                s_beat  <= tx_q[sent];
            end else begin
                s_valid <= 1'b0;
            end
            m_ready <= random_ready ? take_bit() : 1'b1;
        end
        check_value("input beats accepted", 128'(sent), 128'(tx_q.size()));
        s_valid <= 1'b0;
        m_ready <= 1'b1;
    endtask

    task automatic begin_test(input string name);
        $display("test: %s", name);
        tx_q.delete();
        exp_q.delete();
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_ttl_decrement();
        begin_test("ttl decrement");
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd64, 16'h1c46), 5, 8'h3c, 8'hf0);
        run_stream(1'b0);
        check_value("ttl of beat 1", 128'(rx_q[1].data[63:56]), 128'(8'd63));
    endtask

    task automatic test_bad_checksum();
        logic [159:0] h;
        h        = make_header(`IPV4_TTL_VER_IHL, 8'd64, 16'h2001);
        h[79:64] = h[79:64] ^ 16'h0101;
        begin_test("corrupted checksum");
        add_packet(h, 5, 8'h07, 8'hff);
        run_stream(1'b0);
    endtask

    task automatic test_ttl_zero();
        begin_test("ttl zero");
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd0, 16'hbadd), 5, 8'h11, 8'hfc);
        run_stream(1'b0);
    endtask

    task automatic test_bad_version();
        begin_test("version byte 0x46");
        add_packet(make_header(8'h46, 8'd64, 16'h4242), 5, 8'h5a, 8'hc0);
        run_stream(1'b0);
    endtask

    task automatic test_runt();
        begin_test("runt of 2 beats");
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd64, 16'h0055), 2, 8'h21, 8'h0f);
        run_stream(1'b0);
    endtask

    // mixed verdicts and lengths, random output stalls
    task automatic test_back_to_back();
        logic [159:0] bad;
        bad        = make_header(`IPV4_TTL_VER_IHL, 8'd128, 16'h0301);
        bad[79:64] = bad[79:64] ^ 16'h8001;
        begin_test("back-to-back under random m_ready");
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd64, 16'h0101), 4,
                   port_id_t'(rand_bits(8)), 8'hff);
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd1, 16'h0202), 7,
                   port_id_t'(rand_bits(8)), 8'h80);
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd0, 16'h0303), 3,
                   port_id_t'(rand_bits(8)), 8'hfe);
        add_packet(bad, 6, port_id_t'(rand_bits(8)), 8'hc0);
        add_packet(make_header(`IPV4_TTL_VER_IHL, 8'd255, 16'h0505), 5,
                   port_id_t'(rand_bits(8)), 8'hff);
        run_stream(1'b1);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        lfsr_q  = 32'hdd71_a5bb;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        m_ready = 1'b1;
        repeat (4) @(posedge packet_data_in);
        rst <= 1'b0;
        @(posedge packet_data_in);
        check_value("m_valid after reset", 128'(m_valid), 128'(1'b0));
        check_value("s_ready after reset", 128'(s_ready), 128'(1'b1));
        test_ttl_decrement();
        test_bad_checksum();
        test_ttl_zero();
        test_bad_version();
        test_runt();
        test_back_to_back();
        // no extra beat once every packet has left
        repeat (4) begin
            @(posedge packet_data_in);
            check_value("m_valid when idle", 128'(m_valid), 128'(1'b0));
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge packet_data_in);
        $display("watchdog: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/ipv4_ttl_path.sv
//////////////////////////////////////////////////
// ipv4 ttl forwarding stage
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module ipv4_ttl_path (
    input  var logic                      packet_data_in,
    input  var logic                      rst,
    input  var logic                      s_valid,
    output var logic                      s_ready,
    input  var axis_types_pkg::in_beat_t  s_beat,
    output var logic                      m_valid,
    input  var logic                      m_ready,
    output var axis_types_pkg::out_beat_t m_beat
);

    import axis_types_pkg::*;
    import ipv4_hdr_pkg::*;

    hdr_state_e    state;
    hdr_beat_idx_t beat_idx;
    logic          hdr_in_done;
    logic          flush_done;
    logic          runt;
    logic          body_last_out;
    logic          in_fire;
    logic          out_fire;
    logic          hdr_ok;
    logic          ttl_expired;
    logic [$bits(beat_data_t)/2-1:0] patch_word;

    //////////////////////////////////////////////////
    // control

    hdr_edit_fsm u_fsm (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .hdr_in_done    (hdr_in_done),
        .runt           (runt),
        .flush_done     (flush_done),
        .body_last_out  (body_last_out),
        .state          (state)
    );

    hdr_beat_counter u_counter (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .state          (state),
        .in_fire        (in_fire),
        .out_fire       (out_fire),
        .beat_idx       (beat_idx),
        .hdr_in_done    (hdr_in_done),
        .flush_done     (flush_done)
    );

    //////////////////////////////////////////////////
    // datapath

    ipv4_checksum_unit u_csum (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .in_fire        (in_fire),
        .beat_idx       (beat_idx),
        .beat_data      (s_beat.data),
        .hdr_ok         (hdr_ok),
        .ttl_expired    (ttl_expired),
        .patch_word     (patch_word)
    );

    ipv4_hdr_editor u_editor (
        .packet_data_in (packet_data_in),
        .rst            (rst),
        .state          (state),
        .beat_idx       (beat_idx),
        .hdr_ok         (hdr_ok),
        .ttl_expired    (ttl_expired),
        .patch_word     (patch_word),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .s_beat         (s_beat),
        .m_valid        (m_valid),
        .m_ready        (m_ready),
        .m_beat         (m_beat),
        .in_fire        (in_fire),
        .out_fire       (out_fire),
        .runt           (runt),
        .body_last_out  (body_last_out)
    );

endmodule

`default_nettype wire

//--- hw/ipv4_hdr_editor.sv
//////////////////////////////////////////////////
// ipv4 header editor
// header buffer, ttl patch and body output register
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module ipv4_hdr_editor (
    input  var logic                        packet_data_in,
    input  var logic                        rst,
    input  var ipv4_hdr_pkg::hdr_state_e    state,
    input  var ipv4_hdr_pkg::hdr_beat_idx_t beat_idx,
    input  var logic                        hdr_ok,
    input  var logic                        ttl_expired,
    input  var logic [$bits(axis_types_pkg::beat_data_t)/2-1:0] patch_word,
    input  var logic                        s_valid,
    output var logic                        s_ready,
    input  var axis_types_pkg::in_beat_t    s_beat,
    output var logic                        m_valid,
    input  var logic                        m_ready,
    output var axis_types_pkg::out_beat_t   m_beat,
    output var logic                        in_fire,
    output var logic                        out_fire,
    output var logic                        runt,
    output var logic                        body_last_out
);

    import axis_types_pkg::*;
    import ipv4_hdr_pkg::*;

    localparam int            DATA_BITS  = `IPV4_TTL_DATA_BYTES * 8;
    localparam int            PATCH_BITS = DATA_BITS / 2;
    localparam hdr_beat_idx_t LAST_IDX   = hdr_beat_idx_t'(`IPV4_TTL_HDR_BEATS - 1);
    // ttl, protocol and checksum live in beat 1
    localparam hdr_beat_idx_t PATCH_IDX  = hdr_beat_idx_t'(1);

    in_beat_t   hdr_buf [`IPV4_TTL_HDR_BEATS];
    logic       runt_q;
    out_beat_t  body_q;
    logic       body_v;
    logic       body_fire;
    out_meta_t  meta;
    in_beat_t   flush_beat;
    beat_data_t flush_data;
    logic       patch_en;

    //////////////////////////////////////////////////
    // input side

    // closed in check and flush
    // in body, no next-packet beat once last sits in the register
    always_comb begin
        unique case (state)
            collect: s_ready = 1'b1;
            body:    s_ready = !body_v || (m_ready && !body_q.last);
            default: s_ready = 1'b0;
        endcase
    end

    // in_fire only for header beats
    assign in_fire   = s_valid && s_ready && (state == collect);
    assign body_fire = s_valid && s_ready && (state == body);

    // last before the third header beat
    assign runt = in_fire && s_beat.last && (beat_idx != LAST_IDX);

    always_ff @(posedge packet_data_in) begin
        if (in_fire) begin
            hdr_buf[beat_idx] <= s_beat;
        end
    end

    // remembered across flush so the verdict is forced low
    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            runt_q <= 1'b0;
        end else if (in_fire) begin
            runt_q <= runt;
        end
    end

    //////////////////////////////////////////////////
    // sideband and patch

    // port taken from the first header beat for the whole packet
    assign meta.port_id     = hdr_buf[0].meta.port_id;
    assign meta.hdr_ok      = hdr_ok && !runt_q;
    assign meta.ttl_expired = ttl_expired && !runt_q;

    assign patch_en   = meta.hdr_ok && !meta.ttl_expired && (beat_idx == PATCH_IDX);
    assign flush_beat = hdr_buf[beat_idx];
    assign flush_data = patch_en ? {patch_word, flush_beat.data[PATCH_BITS-1:0]}
                                 : flush_beat.data;

    //////////////////////////////////////////////////
    // body output register

    always_ff @(posedge packet_data_in) begin
        if (body_fire) begin
            body_q <= '{data: s_beat.data, keep: s_beat.keep, last: s_beat.last, meta: meta};
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            body_v <= 1'b0;
        end else if (body_fire) begin
            body_v <= 1'b1;
        end else if (out_fire && (state == body)) begin
            body_v <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // output side

    // header beats straight from the buffer, body from the register
    always_comb begin
        if (state == body) begin
            m_valid = body_v;
            m_beat  = body_q;
        end else begin
            m_valid = (state == flush);
            m_beat  = '{data: flush_data, keep: flush_beat.keep, last: flush_beat.last,
                        meta: meta};
        end
    end

    assign out_fire      = m_valid && m_ready;
    assign body_last_out = out_fire && m_beat.last;

endmodule

`default_nettype wire

//--- hw/ipv4_checksum_unit.sv
//////////////////////////////////////////////////
// ipv4 checksum unit
// header sum check and incremental ttl rewrite
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module ipv4_checksum_unit (
    input  var logic                        packet_data_in,
    input  var logic                        rst,
    input  var logic                        in_fire,
    input  var ipv4_hdr_pkg::hdr_beat_idx_t beat_idx,
    input  var axis_types_pkg::beat_data_t  beat_data,
    output var logic                        hdr_ok,
    output var logic                        ttl_expired,
    // new ttl, protocol and checksum for header bytes 8 to 11
    output var logic [$bits(axis_types_pkg::beat_data_t)/2-1:0] patch_word
);

    import ipv4_hdr_pkg::*;

    localparam int DATA_BITS      = `IPV4_TTL_DATA_BYTES * 8;
    localparam int WORDS_PER_BEAT = `IPV4_TTL_DATA_BYTES / 2;
    // 20 header bytes
    localparam int HDR_WORDS      = 10;

    csum_t      sum_q;
    logic [7:0] ver_ihl_q;
    ipv4_word_t ttl_proto_q;
    csum_t      old_csum_q;
    csum_t      beat_sum;
    ttl_t       old_ttl;
    ttl_t       new_ttl;
    ipv4_word_t new_word;
    csum_t      new_csum;

    // 16-bit add with end-around carry
    function automatic csum_t ones_add(input csum_t a, input csum_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + csum_t'(s[16]);
    endfunction

    //////////////////////////////////////////////////
    // per-beat word sum

    // words past the header end are skipped, so beat 2 adds only two
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < WORDS_PER_BEAT; i++) begin
            if (int'(beat_idx) * WORDS_PER_BEAT + i < HDR_WORDS) begin
                beat_sum = ones_add(beat_sum, beat_data[DATA_BITS-1-16*i -: 16]);
            end
        end
    end

    // running sum, restarted by beat 0
    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            sum_q     <= '0;
            ver_ihl_q <= '0;
        end else if (in_fire) begin
            if (beat_idx == '0) begin
                sum_q     <= beat_sum;
                ver_ihl_q <= beat_data[DATA_BITS-1 -: 8];
            end else begin
                sum_q <= ones_add(sum_q, beat_sum);
            end
        end
    end

    // ttl/protocol word and old checksum sit at the top of beat 1
    always_ff @(posedge packet_data_in) begin
        if (in_fire && (beat_idx == hdr_beat_idx_t'(1))) begin
            ttl_proto_q <= beat_data[DATA_BITS-1 -: 16];
            old_csum_q  <= beat_data[DATA_BITS-17 -: 16];
        end
    end

    //////////////////////////////////////////////////
    // verdict and rewrite

    assign old_ttl  = ttl_proto_q[15:8];
    assign new_ttl  = old_ttl - ttl_t'(1);
    assign new_word = {new_ttl, ttl_proto_q[7:0]};

    // HC' = ~(~HC + ~m + m')
    assign new_csum = ~ones_add(ones_add(~old_csum_q, ~ttl_proto_q), new_word);

    // good sum folds to all ones
    assign hdr_ok      = (sum_q == 16'hffff) && (ver_ihl_q == `IPV4_TTL_VER_IHL);
    assign ttl_expired = hdr_ok && (old_ttl == '0);
    assign patch_word  = {new_word, new_csum};

endmodule

`default_nettype wire

//--- hw/hdr_edit_fsm.sv
//////////////////////////////////////////////////
// header edit FSM
// sequences collect, check, flush and body phases
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module hdr_edit_fsm (
    input  var logic                     packet_data_in,
    input  var logic                     rst,
    // third header beat accepted
    input  var logic                     hdr_in_done,
    // packet ended before the header was complete
    input  var logic                     runt,
    // third header beat emitted
    input  var logic                     flush_done,
    // a beat carrying last left the output
    input  var logic                     body_last_out,
    output var ipv4_hdr_pkg::hdr_state_e state
);

    import ipv4_hdr_pkg::*;

    hdr_state_e state_q;
    hdr_state_e state_next;

    //////////////////////////////////////////////////
    // next state

    always_comb begin
        state_next = state_q;
        unique case (state_q)
            collect: begin
                // a runt skips the verdict cycle
                if (runt) begin
                    state_next = flush;
                end else if (hdr_in_done) begin
                    state_next = check;
                end
            end
            check: begin
                // verdict is ready after exactly one cycle
                state_next = flush;
            end
            flush: begin
                // last wins, covers runts and 3-beat packets
                if (body_last_out) begin
                    state_next = collect;
                end else if (flush_done) begin
                    state_next = body;
                end
            end
            body: begin
                if (body_last_out) begin
                    state_next = collect;
                end
            end
            default: begin
                state_next = collect;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // state register

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            state_q <= collect;
        end else begin
            state_q <= state_next;
        end
    end

    assign state = state_q;

endmodule

`default_nettype wire

//--- hw/hdr_beat_counter.sv
//////////////////////////////////////////////////
// header beat counter
// tracks header beats accepted in and emitted out
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

module hdr_beat_counter (
    input  var logic                       packet_data_in,
    input  var logic                       rst,
    input  var ipv4_hdr_pkg::hdr_state_e   state,
    input  var logic                       in_fire,
    input  var logic                       out_fire,
    output var ipv4_hdr_pkg::hdr_beat_idx_t beat_idx,
    output var logic                       hdr_in_done,
    output var logic                       flush_done
);

    import ipv4_hdr_pkg::*;

    localparam hdr_beat_idx_t LAST_IDX = hdr_beat_idx_t'(`IPV4_TTL_HDR_BEATS - 1);

    hdr_state_e    state_q;
    hdr_beat_idx_t count_q;
    logic          state_changed;
    logic          step;

    // first cycle of any new state reads as index 0
    assign state_changed = (state != state_q);
    assign beat_idx      = state_changed ? '0 : count_q;

    // collect counts accepted beats, flush counts emitted ones
    assign step = ((state == collect) && in_fire) || ((state == flush) && out_fire);

    // done pulses on the final header beat
    assign hdr_in_done = (state == collect) && in_fire && (beat_idx == LAST_IDX);
    assign flush_done  = (state == flush) && out_fire && (beat_idx == LAST_IDX);

    always_ff @(posedge packet_data_in) begin
        if (rst) begin
            state_q <= collect;
            count_q <= '0;
        end else begin
            state_q <= state;
            if (step) begin
                count_q <= beat_idx + hdr_beat_idx_t'(1);
            end else begin
                count_q <= beat_idx;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ipv4_hdr_pkg.sv
//////////////////////////////////////////////////
// ipv4 header types
// header field widths and the header FSM states
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

package ipv4_hdr_pkg;

    //////////////////////////////////////////////////
    // header fields

    // one 16-bit word of the header, network order
    typedef logic [15:0] ipv4_word_t;

    // ones-complement checksum
    typedef logic [15:0] csum_t;

    typedef logic [7:0] ttl_t;

    // which header beat is being stored or emitted
    typedef logic [$clog2(`IPV4_TTL_HDR_BEATS)-1:0] hdr_beat_idx_t;

    //////////////////////////////////////////////////
    // FSM states

    // collect  store header beats
    // check    one cycle for the verdict
    // flush    emit held header beats
    // body     registered pass-through of the payload
    typedef enum logic [1:0] {
        collect,
        check,
        flush,
        body
    } hdr_state_e;

endpackage

`default_nettype wire

//--- hw/axis_types_pkg.sv
//////////////////////////////////////////////////
// packet stream types
// beat payload, byte enables and sideband structs
//////////////////////////////////////////////////

`default_nettype none

`include "ipv4_ttl_path_config.svh"

package axis_types_pkg;

    // raw beat fields
    typedef logic [`IPV4_TTL_DATA_BYTES*8-1:0] beat_data_t;
    typedef logic [`IPV4_TTL_DATA_BYTES-1:0]   beat_keep_t;
    typedef logic [`IPV4_TTL_PORT_BITS-1:0]    port_id_t;

    // sideband on the way in
    typedef struct packed {
        port_id_t port_id;
    } in_meta_t;

    // sideband on the way out, port echoed plus verdict flags
    typedef struct packed {
        port_id_t port_id;
        logic     hdr_ok;
        logic     ttl_expired;
    } out_meta_t;

    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        in_meta_t   meta;
    } in_beat_t;

    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        out_meta_t  meta;
    } out_beat_t;

endpackage

`default_nettype wire

//--- hw/ipv4_ttl_path_config.svh
//////////////////////////////////////////////////
// ipv4 ttl path configuration
// beat geometry and fixed header constants
//////////////////////////////////////////////////

`ifndef IPV4_TTL_PATH_CONFIG_SVH
`define IPV4_TTL_PATH_CONFIG_SVH

// bytes carried per stream beat
`define IPV4_TTL_DATA_BYTES 8

// 20-byte header spans three 8-byte beats
`define IPV4_TTL_HDR_BEATS 3

// ingress port sideband width
`define IPV4_TTL_PORT_BITS 8

// version 4, ihl 5 (no options)
`define IPV4_TTL_VER_IHL 8'h45

`endif
